//--- rtl/mem_bridge_defs.svh
`ifndef MEM_BRIDGE_DEFS_SVH
`define MEM_BRIDGE_DEFS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------

// client and controller address
`define MB_ADDR_W 32

// one data beat
`define MB_DATA_W 144

// one enable per data byte
`define MB_BE_W 18

// ----------------------------------------
// queue depths
// ----------------------------------------

// command and write-data queues
`define MB_CMD_DEPTH 8

// read-data queue, also the read credit limit
`define MB_RD_DEPTH 4

`endif

//--- rtl/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // ----------------------------------------
    // transaction opcode
    // ----------------------------------------

    // one bit, stored next to the address in the command queue
    typedef enum logic [0:0] {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } txn_op_e;

    // ----------------------------------------
    // issue stage state
    // ----------------------------------------

    // idle issues freely
    // wait_credit holds a read at the head until a beat is returned
    typedef enum logic [0:0] {
        ISSUE_IDLE        = 1'b0,
        ISSUE_WAIT_CREDIT = 1'b1
    } issue_state_e;

endpackage

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             dram_clk,
    input  logic             arst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage, no reset needed
    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // ----------------------------------------
    // write side
    // ----------------------------------------

    always_ff @(posedge dram_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap at DEPTH, so any depth works
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // flags and show-ahead head
    // ----------------------------------------

    assign dout        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    // exactly one slot free
    assign almost_full = (count == CNT_W'(DEPTH - 1));

    // callers must look at the flags before they push or pop
    a_no_overflow: assert property (@(posedge dram_clk) disable iff (!arst_n)
        !(push && full));
    a_no_underflow: assert property (@(posedge dram_clk) disable iff (!arst_n)
        !(pop && empty));

endmodule

//--- rtl/cmd_capture.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module cmd_capture (
    input  logic                      dram_clk,
    input  logic                      arst_n,
    input  logic                      cmd_valid,
    input  logic                      cmd_rnw,
    input  logic [`MB_ADDR_W-1:0]     cmd_addr,
    input  logic [`MB_DATA_W-1:0]     wr_din,
    input  logic [`MB_BE_W-1:0]       wr_be,
    output logic                      mem_rdy,
    output logic                      cmd_ack,
    input  logic                      cmd_pop,
    input  logic                      data_pop,
    output mem_bridge_pkg::txn_op_e   cmd_op,
    output logic [`MB_ADDR_W-1:0]     cmd_addr_q,
    output logic                      cmd_empty,
    output logic [`MB_DATA_W-1:0]     wr_data_q,
    output logic [`MB_BE_W-1:0]       wr_be_q
);

    import mem_bridge_pkg::*;

    localparam int CMD_W  = `MB_ADDR_W + 1;
    localparam int DATA_W = `MB_DATA_W + `MB_BE_W;

    txn_op_e            op_in;
    logic               cmd_push;
    logic               data_push;
    logic [CMD_W-1:0]   cmd_din;
    logic [CMD_W-1:0]   cmd_dout;
    logic               cmd_full;
    logic               cmd_afull;
    logic [DATA_W-1:0]  data_dout;
    logic               data_full;
    logic               data_afull;

    // ----------------------------------------
    // client handshake
    // ----------------------------------------

    assign cmd_ack   = cmd_valid & mem_rdy;
    assign op_in     = cmd_rnw ? OP_READ : OP_WRITE;
    assign cmd_push  = cmd_ack;
    // reads carry no payload
    assign data_push = cmd_ack & (op_in == OP_WRITE);
    assign cmd_din   = {op_in, cmd_addr};

    // ready for next cycle
    // drop when full, or when the last slot is taken right now
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rdy <= 1'b0;
        end else begin
            mem_rdy <= ~(cmd_full | data_full
                         | (cmd_afull & cmd_push)
                         | (data_afull & data_push));
        end
    end

    // ----------------------------------------
    // command and write-data queues
    // ----------------------------------------

    // opcode in the msb, address below
    sync_fifo #(.WIDTH(CMD_W), .DEPTH(`MB_CMD_DEPTH)) u_cmd_fifo (
        .dram_clk    (dram_clk),
        .arst_n      (arst_n),
        .push        (cmd_push),
        .pop         (cmd_pop),
        .din         (cmd_din),
        .dout        (cmd_dout),
        .empty       (cmd_empty),
        .full        (cmd_full),
        .almost_full (cmd_afull)
    );

    // data then byte enables
    sync_fifo #(.WIDTH(DATA_W), .DEPTH(`MB_CMD_DEPTH)) u_data_fifo (
        .dram_clk    (dram_clk),
        .arst_n      (arst_n),
        .push        (data_push),
        .pop         (data_pop),
        .din         ({wr_din, wr_be}),
        .dout        (data_dout),
        .empty       (),
        .full        (data_full),
        .almost_full (data_afull)
    );

    assign cmd_op     = txn_op_e'(cmd_dout[`MB_ADDR_W]);
    assign cmd_addr_q = cmd_dout[`MB_ADDR_W-1:0];
    assign wr_data_q  = data_dout[DATA_W-1:`MB_BE_W];
    assign wr_be_q    = data_dout[`MB_BE_W-1:0];

    // registered ready must already cover the queue state this cycle
    a_ack_has_room: assert property (@(posedge dram_clk) disable iff (!arst_n)
        cmd_ack |-> mem_rdy && !cmd_full && (cmd_rnw || !data_full));

endmodule

//--- rtl/dram_issue.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module dram_issue (
    input  logic                      dram_clk,
    input  logic                      arst_n,
    input  mem_bridge_pkg::txn_op_e   cmd_op,
    input  logic [`MB_ADDR_W-1:0]     cmd_addr_q,
    input  logic                      cmd_empty,
    input  logic [`MB_DATA_W-1:0]     wr_data_q,
    input  logic [`MB_BE_W-1:0]       wr_be_q,
    output logic                      cmd_pop,
    output logic                      data_pop,
    input  logic                      rd_pop,
    input  logic                      dram_ready,
    output logic                      dram_cmd_en,
    output logic                      dram_rnw,
    output logic [`MB_ADDR_W-1:0]     dram_address,
    output logic [`MB_DATA_W-1:0]     dram_wr_data,
    output logic [`MB_BE_W-1:0]       dram_byte_enable
);

    import mem_bridge_pkg::*;

    localparam int CNT_W = $clog2(`MB_RD_DEPTH + 1);

    issue_state_e      state;
    logic [CNT_W-1:0]  rd_cnt;
    logic              credit_free;
    logic              head_read;
    logic              issue_go;
    logic              rd_issue;

    // ----------------------------------------
    // issue decision
    // ----------------------------------------

    assign credit_free = (rd_cnt < CNT_W'(`MB_RD_DEPTH));
    assign head_read   = !cmd_empty && (cmd_op == OP_READ);

    // writes need no credit and reads need a free read-queue slot
    assign issue_go = (state == ISSUE_IDLE) && !cmd_empty && dram_ready
                      && ((cmd_op == OP_WRITE) || credit_free);
    assign rd_issue = issue_go && (cmd_op == OP_READ);

    // pop both queues together on writes
    assign cmd_pop  = issue_go;
    assign data_pop = issue_go && (cmd_op == OP_WRITE);

    // stall state left once a credit comes back
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ISSUE_IDLE;
        end else begin
            case (state)
                ISSUE_IDLE: begin
                    if (head_read && !credit_free && !rd_pop) begin
                        state <= ISSUE_WAIT_CREDIT;
                    end
                end
                ISSUE_WAIT_CREDIT: begin
                    if (rd_pop) begin
                        state <= ISSUE_IDLE;
                    end
                end
                default: state <= ISSUE_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // read credits
    // ----------------------------------------

    // reads in flight plus beats waiting in the read queue
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_cnt <= '0;
        end else begin
            case ({rd_issue, rd_pop})
                2'b10:   rd_cnt <= rd_cnt + 1'b1;
                2'b01:   rd_cnt <= rd_cnt - 1'b1;
                default: rd_cnt <= rd_cnt;
            endcase
        end
    end

    // ----------------------------------------
    // controller port
    // ----------------------------------------

    // one-cycle strobe
    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            dram_cmd_en <= 1'b0;
        end else begin
            dram_cmd_en <= issue_go;
        end
    end

    // payload valid with the strobe
    always_ff @(posedge dram_clk) begin
        if (issue_go) begin
            dram_rnw         <= (cmd_op == OP_READ);
            dram_address     <= cmd_addr_q;
            dram_wr_data     <= wr_data_q;
            dram_byte_enable <= wr_be_q;
        end
    end

    // credits stay bounded and are never returned without a read out
    a_credit_bound: assert property (@(posedge dram_clk) disable iff (!arst_n)
        (rd_cnt <= CNT_W'(`MB_RD_DEPTH)) && !(rd_pop && (rd_cnt == '0)));

endmodule

//--- rtl/read_return.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module read_return (
    input  logic                   dram_clk,
    input  logic                   arst_n,
    input  logic                   dram_data_valid,
    input  logic [`MB_DATA_W-1:0]  dram_rd_data,
    output logic [`MB_DATA_W-1:0]  rd_dout,
    output logic                   rd_valid,
    input  logic                   rd_ack,
    output logic                   rd_pop
);

    logic                   beat_valid;
    logic [`MB_DATA_W-1:0]  beat_data;
    logic                   fifo_empty;
    logic                   fifo_full;

    // ----------------------------------------
    // input register
    // ----------------------------------------

    always_ff @(posedge dram_clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= dram_data_valid;
        end
    end

    // beat payload
    always_ff @(posedge dram_clk) begin
        if (dram_data_valid) begin
            beat_data <= dram_rd_data;
        end
    end

    // ----------------------------------------
    // read-data queue
    // ----------------------------------------

    // sized to the credit limit, no stall toward the controller
    sync_fifo #(.WIDTH(`MB_DATA_W), .DEPTH(`MB_RD_DEPTH)) u_rd_fifo (
        .dram_clk    (dram_clk),
        .arst_n      (arst_n),
        .push        (beat_valid),
        .pop         (rd_pop),
        .din         (beat_data),
        .dout        (rd_dout),
        .empty       (fifo_empty),
        .full        (fifo_full),
        .almost_full ()
    );

    // client side, each pop gives a credit back to issue
    assign rd_valid = !fifo_empty;
    assign rd_pop   = rd_valid & rd_ack;

    // credit scheme upstream keeps a slot free for every beat
    a_beat_has_slot: assert property (@(posedge dram_clk) disable iff (!arst_n)
        dram_data_valid |=> !fifo_full);

endmodule

//--- rtl/mem_bridge_top.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module mem_bridge_top (
    input  logic                   dram_clk,
    input  logic                   arst_n,
    // client command
    input  logic                   cmd_valid,
    input  logic                   cmd_rnw,
    input  logic [`MB_ADDR_W-1:0]  cmd_addr,
    input  logic [`MB_DATA_W-1:0]  wr_din,
    input  logic [`MB_BE_W-1:0]    wr_be,
    output logic                   mem_rdy,
    output logic                   cmd_ack,
    // client read return
    output logic [`MB_DATA_W-1:0]  rd_dout,
    output logic                   rd_valid,
    input  logic                   rd_ack,
    // controller
    input  logic                   dram_ready,
    output logic                   dram_cmd_en,
    output logic                   dram_rnw,
    output logic [`MB_ADDR_W-1:0]  dram_address,
    output logic [`MB_DATA_W-1:0]  dram_wr_data,
    output logic [`MB_BE_W-1:0]    dram_byte_enable,
    input  logic                   dram_data_valid,
    input  logic [`MB_DATA_W-1:0]  dram_rd_data
);

    import mem_bridge_pkg::*;

    // ----------------------------------------
    // stage links
    // ----------------------------------------

    txn_op_e                cmd_op;
    logic [`MB_ADDR_W-1:0]  cmd_addr_q;
    logic                   cmd_empty;
    logic [`MB_DATA_W-1:0]  wr_data_q;
    logic [`MB_BE_W-1:0]    wr_be_q;
    logic                   cmd_pop;
    logic                   data_pop;
    logic                   rd_pop;

    // stage 1, capture
    cmd_capture u_cmd_capture (
        .dram_clk   (dram_clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_rnw    (cmd_rnw),
        .cmd_addr   (cmd_addr),
        .wr_din     (wr_din),
        .wr_be      (wr_be),
        .mem_rdy    (mem_rdy),
        .cmd_ack    (cmd_ack),
        .cmd_pop    (cmd_pop),
        .data_pop   (data_pop),
        .cmd_op     (cmd_op),
        .cmd_addr_q (cmd_addr_q),
        .cmd_empty  (cmd_empty),
        .wr_data_q  (wr_data_q),
        .wr_be_q    (wr_be_q)
    );

    // stage 2, issue to controller
    dram_issue u_dram_issue (
        .dram_clk         (dram_clk),
        .arst_n           (arst_n),
        .cmd_op           (cmd_op),
        .cmd_addr_q       (cmd_addr_q),
        .cmd_empty        (cmd_empty),
        .wr_data_q        (wr_data_q),
        .wr_be_q          (wr_be_q),
        .cmd_pop          (cmd_pop),
        .data_pop         (data_pop),
        .rd_pop           (rd_pop),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_wr_data     (dram_wr_data),
        .dram_byte_enable (dram_byte_enable)
    );

    // stage 3, read data back to client
    read_return u_read_return (
        .dram_clk        (dram_clk),
        .arst_n          (arst_n),
        .dram_data_valid (dram_data_valid),
        .dram_rd_data    (dram_rd_data),
        .rd_dout         (rd_dout),
        .rd_valid        (rd_valid),
        .rd_ack          (rd_ack),
        .rd_pop          (rd_pop)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic dram_clk,
    output logic arst_n
);

    // free-running clock
    initial begin
        dram_clk = 1'b0;
        forever #(PERIOD / 2) dram_clk = ~dram_clk;
    end

    // reset held over the first rising edges, released just after the last
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge dram_clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

//--- dv/dram_model.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module dram_model (
    input  logic                   dram_clk,
    input  logic                   arst_n,
    input  logic                   ready_rand,
    input  logic                   hold_ready,
    input  logic [1:0]             lat_rand,
    output logic                   dram_ready,
    input  logic                   dram_cmd_en,
    input  logic                   dram_rnw,
    input  logic [`MB_ADDR_W-1:0]  dram_address,
    input  logic [`MB_DATA_W-1:0]  dram_wr_data,
    input  logic [`MB_BE_W-1:0]    dram_byte_enable,
    output logic                   dram_data_valid,
    output logic [`MB_DATA_W-1:0]  dram_rd_data,
    output int                     cmd_cnt,
    output int                     proto_errs
);

    // 16-word window, indexed by the low address bits
    logic [`MB_DATA_W-1:0] mem [16];
    logic [`MB_DATA_W-1:0] beat_q [$];
    int                    due_q [$];

    // ready pattern comes from the testbench, hold forces it low
    assign dram_ready = ready_rand & !hold_ready;

    initial begin
        int         cyc;
        int         due;
        int         last_due;
        logic       ready_prev;
        logic [3:0] idx;
        cyc             = 0;
        last_due        = -1;
        ready_prev      = 1'b0;
        cmd_cnt         = 0;
        proto_errs      = 0;
        dram_data_valid = 1'b0;
        dram_rd_data    = '0;
        forever begin
            @(posedge dram_clk);
            cyc++;
            // ----------------------------------------
            // command capture
            // ----------------------------------------
            if (arst_n && dram_cmd_en) begin
                cmd_cnt++;
                idx = dram_address[3:0];
                // strobe is only legal after a ready cycle
                if (!ready_prev) begin
                    proto_errs++;
                    $display("controller model: dram_cmd_en at %0t without dram_ready before",
                             $time);
                end
                if (dram_rnw) begin
                    // in order, at most one beat per cycle
                    due = cyc + int'(lat_rand);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    beat_q.push_back(mem[idx]);
                    due_q.push_back(due);
                    last_due = due;
                end else begin
                    for (int b = 0; b < `MB_BE_W; b++) begin
                        if (dram_byte_enable[b]) begin
                            mem[idx][8*b +: 8] = dram_wr_data[8*b +: 8];
                        end
                    end
                end
            end
            ready_prev = dram_ready;
            // ----------------------------------------
            // read return
            // ----------------------------------------
            #1;
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                dram_data_valid = 1'b1;
                dram_rd_data    = beat_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                dram_data_valid = 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_mem_bridge.sv
`timescale 1ns/1ns
`include "mem_bridge_defs.svh"

module tb_mem_bridge;

    import mem_bridge_pkg::*;

    localparam int ACK_LIMIT   = 300;
    localparam int DRAIN_LIMIT = 5000;

    logic                   dram_clk;
    logic                   arst_n;
    logic                   cmd_valid;
    logic                   cmd_rnw;
    logic [`MB_ADDR_W-1:0]  cmd_addr;
    logic [`MB_DATA_W-1:0]  wr_din;
    logic [`MB_BE_W-1:0]    wr_be;
    logic                   mem_rdy;
    logic                   cmd_ack;
    logic [`MB_DATA_W-1:0]  rd_dout;
    logic                   rd_valid;
    logic                   rd_ack;
    logic                   dram_ready;
    logic                   dram_cmd_en;
    logic                   dram_rnw;
    logic [`MB_ADDR_W-1:0]  dram_address;
    logic [`MB_DATA_W-1:0]  dram_wr_data;
    logic [`MB_BE_W-1:0]    dram_byte_enable;
    logic                   dram_data_valid;
    logic [`MB_DATA_W-1:0]  dram_rd_data;

    // controller model knobs and counters
    logic                   ready_rand;
    logic                   hold_ready;
    logic [1:0]             lat_rand;
    int                     cmd_cnt;
    int                     proto_errs;

    // reference model, read values queued at acceptance
    logic [`MB_DATA_W-1:0]  ref_mem [16];
    logic [`MB_DATA_W-1:0]  exp_q [$];
    logic [31:0]            lcg_state = 32'h875e;
    string                  test_name;
    int                     n_acc_total;
    int                     n_rd_acc;
    int                     n_ret;
    int                     value_errs;
    int                     other_errs;
    int                     mon_errs;
    int                     mon_extra;

    tb_clk_gen u_clk_gen (
        .dram_clk (dram_clk),
        .arst_n   (arst_n)
    );

    mem_bridge_top dut (
        .dram_clk         (dram_clk),
        .arst_n           (arst_n),
        .cmd_valid        (cmd_valid),
        .cmd_rnw          (cmd_rnw),
        .cmd_addr         (cmd_addr),
        .wr_din           (wr_din),
        .wr_be            (wr_be),
        .mem_rdy          (mem_rdy),
        .cmd_ack          (cmd_ack),
        .rd_dout          (rd_dout),
        .rd_valid         (rd_valid),
        .rd_ack           (rd_ack),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_wr_data     (dram_wr_data),
        .dram_byte_enable (dram_byte_enable),
        .dram_data_valid  (dram_data_valid),
        .dram_rd_data     (dram_rd_data)
    );

    dram_model u_dram_model (
        .dram_clk         (dram_clk),
        .arst_n           (arst_n),
        .ready_rand       (ready_rand),
        .hold_ready       (hold_ready),
        .lat_rand         (lat_rand),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_wr_data     (dram_wr_data),
        .dram_byte_enable (dram_byte_enable),
        .dram_data_valid  (dram_data_valid),
        .dram_rd_data     (dram_rd_data),
        .cmd_cnt          (cmd_cnt),
        .proto_errs       (proto_errs)
    );

    // ----------------------------------------
    // random numbers and reference helpers
    // ----------------------------------------

    // lcg, upper half only since the low bits cycle fast
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [`MB_DATA_W-1:0] random_beat();
        logic [`MB_DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < 9; i++) begin
            v = {v[`MB_DATA_W-17:0], next_rand()};
        end
        return v;
    endfunction

    // enabled bytes take the new value
    function automatic logic [`MB_DATA_W-1:0] merge_bytes(input logic [`MB_DATA_W-1:0] old_w,
                                                          input logic [`MB_DATA_W-1:0] new_w,
                                                          input logic [`MB_BE_W-1:0]   be);
        logic [`MB_DATA_W-1:0] v;
        v = old_w;
        for (int b = 0; b < `MB_BE_W; b++) begin
            if (be[b]) begin
                v[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return v;
    endfunction

    // applied at acceptance, the bridge keeps commands in order
    task automatic record_cmd();
        logic [3:0] a;
        a = cmd_addr[3:0];
        if (cmd_rnw) begin
            exp_q.push_back(ref_mem[a]);
            n_rd_acc++;
        end else begin
            ref_mem[a] = merge_bytes(ref_mem[a], wr_din, wr_be);
        end
        n_acc_total++;
    endtask

    // ----------------------------------------
    // client command driving
    // ----------------------------------------

    task automatic drive_cmd(input txn_op_e op, input logic [3:0] a,
                             input logic [`MB_DATA_W-1:0] d, input logic [`MB_BE_W-1:0] be);
        cmd_valid = 1'b1;
        cmd_rnw   = (op == OP_READ);
        cmd_addr  = {28'h0, a};
        wr_din    = d;
        wr_be     = be;
    endtask

    task automatic pick_cmd(input logic full_be);
        logic [15:0]          r;
        logic [`MB_BE_W-1:0]  be;
        txn_op_e              op;
        r  = next_rand();
        op = r[0] ? OP_READ : OP_WRITE;
        be = full_be ? {`MB_BE_W{1'b1}} : {r[15:14], next_rand()};
        drive_cmd(op, r[4:1], random_beat(), be);
    endtask

    // entered and left 1 ns after a rising edge
    task automatic wait_ack();
        int   n;
        logic took;
        n    = 0;
        took = 1'b0;
        while (!took && n < ACK_LIMIT) begin
            @(posedge dram_clk);
            took = cmd_ack;
            n++;
            #1;
        end
        assert (took) else begin
            other_errs++;
            $display("timeout in %s: cmd_ack never came", test_name);
        end
        if (took) begin
            record_cmd();
        end
    endtask

    task automatic idle(input int cycles);
        cmd_valid = 1'b0;
        repeat (cycles) begin
            @(posedge dram_clk);
            #1;
        end
    endtask

    // every accepted command issued and every read returned
    task automatic wait_drain();
        int n;
        n = 0;
        while ((n_ret != n_rd_acc || cmd_cnt != n_acc_total) && n < DRAIN_LIMIT) begin
            @(posedge dram_clk);
            #1;
            n++;
        end
        assert (n_ret == n_rd_acc && cmd_cnt == n_acc_total) else begin
            other_errs++;
            $display("timeout in %s: %0d reads and %0d commands still pending", test_name,
                     n_rd_acc - n_ret, n_acc_total - cmd_cnt);
        end
    endtask

    // ----------------------------------------
    // controller pattern and rd_ack gaps
    // ----------------------------------------

    // drawn at the falling edge, applied after the rising edge
    initial begin
        logic [15:0] r;
        rd_ack     = 1'b0;
        ready_rand = 1'b0;
        lat_rand   = 2'd0;
        forever begin
            @(negedge dram_clk);
            r = next_rand();
            @(posedge dram_clk);
            #1;
            ready_rand = (r[1:0] != 2'b00);
            lat_rand   = r[3:2];
            rd_ack     = r[4];
        end
    end

    // read return checker
    initial begin
        n_ret     = 0;
        mon_errs  = 0;
        mon_extra = 0;
        forever begin
            @(posedge dram_clk);
            if (arst_n && rd_valid && rd_ack) begin
                assert (n_ret < exp_q.size()) else begin
                    mon_extra++;
                    $display("read beat returned while no read was outstanding");
                end
                if (n_ret < exp_q.size()) begin
                    assert (rd_dout === exp_q[n_ret]) else begin
                        mon_errs++;
                        $display("FAILED %s: expected %h, actual %h", test_name,
                                 exp_q[n_ret], rd_dout);
                    end
                end
                n_ret++;
            end
        end
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin
        int          n;
        int          n_hold;
        logic        took;
        logic [15:0] r;
        cmd_valid   = 1'b0;
        cmd_rnw     = 1'b0;
        cmd_addr    = '0;
        wr_din      = '0;
        wr_be       = '0;
        hold_ready  = 1'b0;
        n_acc_total = 0;
        n_rd_acc    = 0;
        value_errs  = 0;
        other_errs  = 0;

        // outputs idle right after reset release, mid-cycle
        test_name = "reset";
        n = 0;
        do begin
            @(negedge dram_clk);
            n++;
        end while (!arst_n && n < 10);
        assert (arst_n) else begin
            other_errs++;
            $display("timeout: reset was never released");
        end
        assert ({mem_rdy, cmd_ack, rd_valid, dram_cmd_en} === 4'b0000) else begin
            value_errs++;
            $display("FAILED %s: expected 0000, actual %b%b%b%b", test_name,
                     mem_rdy, cmd_ack, rd_valid, dram_cmd_en);
        end
        @(posedge dram_clk);
        #1;

        // full write then read back, also fills the whole window
        test_name = "wr_rd_full";
        for (int a = 0; a < 16; a++) begin
            drive_cmd(OP_WRITE, a[3:0], random_beat(), {`MB_BE_W{1'b1}});
            wait_ack();
            drive_cmd(OP_READ, a[3:0], '0, '0);
            wait_ack();
        end
        idle(1);
        wait_drain();

        // partial enables, back to back
        test_name = "partial_be";
        for (int i = 0; i < 60; i++) begin
            pick_cmd(1'b0);
            wait_ack();
        end
        idle(1);
        wait_drain();

        // random gaps on both sides
        test_name = "random_mix";
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            pick_cmd(r[2]);
            wait_ack();
            if (r[1:0] == 2'b00) begin
                idle(int'(r[5:3]) + 1);
            end
        end
        idle(1);
        wait_drain();

        // controller stalled, queue must fill and push back
        test_name  = "queue_full";
        hold_ready = 1'b1;
        idle(2);
        n_hold = 0;
        n      = 0;
        pick_cmd(1'b0);
        while (n < 16) begin
            @(posedge dram_clk);
            took = cmd_ack;
            #1;
            n++;
            if (took) begin
                record_cmd();
                n_hold++;
                pick_cmd(1'b0);
            end
        end
        assert (n_hold == `MB_CMD_DEPTH) else begin
            value_errs++;
            $display("FAILED %s: expected %0d, actual %0d", test_name, `MB_CMD_DEPTH, n_hold);
        end
        // pending command goes in once the queue moves
        hold_ready = 1'b0;
        wait_ack();
        idle(1);
        wait_drain();

        // ----------------------------------------
        // final tallies
        // ----------------------------------------
        test_name = "summary";
        assert (proto_errs == 0) else begin
            other_errs += proto_errs;
            $display("controller model saw %0d commands without ready", proto_errs);
        end
        assert (n_ret == n_rd_acc) else begin
            value_errs++;
            $display("FAILED read_count: expected %0d, actual %0d", n_rd_acc, n_ret);
        end
        assert (cmd_cnt == n_acc_total) else begin
            value_errs++;
            $display("FAILED cmd_count: expected %0d, actual %0d", n_acc_total, cmd_cnt);
        end
        $display("errors: %0d wrong values, %0d other, %0d reads checked",
                 value_errs + mon_errs, other_errs + mon_extra, n_ret);
        if (value_errs + mon_errs + other_errs + mon_extra == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/mem_bridge_pkg.sv
rtl/sync_fifo.sv
rtl/cmd_capture.sv
rtl/dram_issue.sv
rtl/read_return.sv
rtl/mem_bridge_top.sv
dv/tb_clk_gen.sv
dv/dram_model.sv
dv/tb_mem_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_bridge
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
